// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exe_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh) list.f

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f list.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

check: run

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== list.f ====
src/exe_pkg.sv
src/exe_opr_if.sv
src/exe_operand_sel.sv
src/exe_alu.sv
src/exe_bitmanip.sv
src/exe_mul.sv
src/exe_ctrl.sv
src/exe_top.sv
+incdir+tb
tb/tb_exe_top.sv

// ==== src/exe_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_alu (
   exe_opr_if.cmp            opr,
   input  exe_pkg::exe_op_e  op_i,
   input  exe_pkg::br_op_e   br_op_i,
   output exe_pkg::xlen_t    alu_result_o,
   output logic              branch_taken_o
);
   import exe_pkg::*;

   logic [XLEN:0]      cmp_diff;
   logic               cmp_neg;
   logic               cmp_ovf;
   xlen_t              adder_out;
   logic [SHAMT_W-1:0] shamt;

   ////////////////////////////////////////////////////////////////////////////
   // Comparison subtractor
   ////////////////////////////////////////////////////////////////////////////

   // Bit XLEN of the difference is the borrow
   assign cmp_diff = {1'b0, opr.cmp_opr1} - {1'b0, opr.cmp_opr2};
   assign cmp_neg  = cmp_diff[XLEN-1];

   // Signed overflow when operand signs differ and the result sign flips
   assign cmp_ovf = (cmp_neg & ~opr.cmp_opr1[XLEN-1] & opr.cmp_opr2[XLEN-1]) |
                    (~cmp_neg & opr.cmp_opr1[XLEN-1] & ~opr.cmp_opr2[XLEN-1]);

   assign opr.cmp_eq  = ~|cmp_diff[XLEN-1:0];
   assign opr.cmp_lt  = cmp_neg ^ cmp_ovf;
   assign opr.cmp_ltu = cmp_diff[XLEN];

   ////////////////////////////////////////////////////////////////////////////
   // Base ALU
   ////////////////////////////////////////////////////////////////////////////
   assign shamt     = opr.opr2[SHAMT_W-1:0];
   assign adder_out = (op_i == OP_SUB) ? opr.opr1 - opr.opr2 : opr.opr1 + opr.opr2;

   always_comb begin
      case (op_i)
         OP_ADD,
         OP_SUB:   alu_result_o = adder_out;
         OP_AND:   alu_result_o = opr.opr1 & opr.opr2;
         OP_OR:    alu_result_o = opr.opr1 | opr.opr2;
         OP_XOR:   alu_result_o = opr.opr1 ^ opr.opr2;
         OP_SLL:   alu_result_o = opr.opr1 << shamt;
         OP_SRL:   alu_result_o = opr.opr1 >> shamt;
         OP_SRA:   alu_result_o = $signed(opr.opr1) >>> shamt;
         OP_SLT:   alu_result_o = {{(XLEN-1){1'b0}}, opr.cmp_lt};
         OP_SLTU:  alu_result_o = {{(XLEN-1){1'b0}}, opr.cmp_ltu};
         // PC copy for jumps, immediate copy for lui
         OP_COPY1: alu_result_o = opr.opr1;
         OP_COPY2: alu_result_o = opr.opr2;
         default:  alu_result_o = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Branch resolution
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      case (br_op_i)
         BR_EQ:   branch_taken_o = opr.cmp_eq;
         BR_NE:   branch_taken_o = ~opr.cmp_eq;
         BR_LT:   branch_taken_o = opr.cmp_lt;
         BR_GE:   branch_taken_o = ~opr.cmp_lt;
         BR_LTU:  branch_taken_o = opr.cmp_ltu;
         BR_GEU:  branch_taken_o = ~opr.cmp_ltu;
         default: branch_taken_o = 1'b0;
      endcase
   end

endmodule : exe_alu

`default_nettype wire

// ==== src/exe_bitmanip.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_bitmanip (
   exe_opr_if.user           opr,
   input  exe_pkg::exe_op_e  op_i,
   output exe_pkg::xlen_t    bmu_result_o
);
   import exe_pkg::*;

   xlen_t              opr1_rev;
   xlen_t              cnt_data;
   logic [CNT_W-1:0]   cnt_result;
   logic               cnt_run;
   logic               is_cpop;
   logic [SHAMT_W-1:0] shamt;
   logic [2*XLEN-1:0]  rol_full;
   logic [2*XLEN-1:0]  ror_full;

   always_comb begin
      for (int i = 0; i < XLEN; i++) begin
         opr1_rev[i] = opr.opr1[XLEN-1-i];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Shared counter for clz, ctz and cpop
   ////////////////////////////////////////////////////////////////////////////
   assign is_cpop  = (op_i == OP_CPOP);
   assign cnt_data = is_cpop ? opr.opr1 : (op_i == OP_CTZ) ? ~opr.opr1 : ~opr1_rev;

   // Trailing ones from the LSB, cpop never stops
   always_comb begin
      cnt_result = '0;
      cnt_run    = 1'b1;
      for (int i = 0; i < XLEN; i++) begin
         if (cnt_data[i]) begin
            if (cnt_run) begin
               cnt_result = cnt_result + CNT_W'(1);
            end
         end else if (!is_cpop) begin
            cnt_run = 1'b0;
         end
      end
   end

   // Rotates through a doubled word
   assign shamt    = opr.opr2[SHAMT_W-1:0];
   assign rol_full = {opr.opr1, opr.opr1} << shamt;
   assign ror_full = {opr.opr1, opr.opr1} >> shamt;

   always_comb begin
      case (op_i)
         OP_SH1ADD: bmu_result_o = (opr.opr1 << 1) + opr.opr2;
         OP_SH2ADD: bmu_result_o = (opr.opr1 << 2) + opr.opr2;
         OP_SH3ADD: bmu_result_o = (opr.opr1 << 3) + opr.opr2;
         OP_ANDN:   bmu_result_o = opr.opr1 & ~opr.opr2;
         OP_ORN:    bmu_result_o = opr.opr1 | ~opr.opr2;
         OP_XNOR:   bmu_result_o = ~(opr.opr1 ^ opr.opr2);
         OP_CLZ,
         OP_CTZ,
         OP_CPOP:   bmu_result_o = {{(XLEN-CNT_W){1'b0}}, cnt_result};
         // Min and max reuse the ALU comparison flags
         OP_MIN:    bmu_result_o = opr.cmp_lt  ? opr.opr1 : opr.opr2;
         OP_MAX:    bmu_result_o = opr.cmp_lt  ? opr.opr2 : opr.opr1;
         OP_MINU:   bmu_result_o = opr.cmp_ltu ? opr.opr1 : opr.opr2;
         OP_MAXU:   bmu_result_o = opr.cmp_ltu ? opr.opr2 : opr.opr1;
         OP_SEXTB:  bmu_result_o = {{(XLEN-8){opr.opr1[7]}}, opr.opr1[7:0]};
         OP_SEXTH:  bmu_result_o = {{(XLEN-16){opr.opr1[15]}}, opr.opr1[15:0]};
         OP_ZEXTH:  bmu_result_o = {{(XLEN-16){1'b0}}, opr.opr1[15:0]};
         OP_ROL:    bmu_result_o = rol_full[2*XLEN-1:XLEN];
         OP_ROR:    bmu_result_o = ror_full[XLEN-1:0];
         OP_ORCB:   bmu_result_o = {{8{|opr.opr1[31:24]}}, {8{|opr.opr1[23:16]}},
                                    {8{|opr.opr1[15:8]}},  {8{|opr.opr1[7:0]}}};
         OP_REV8:   bmu_result_o = {opr.opr1[7:0],   opr.opr1[15:8],
                                    opr.opr1[23:16], opr.opr1[31:24]};
         default:   bmu_result_o = '0;
      endcase
   end

endmodule : exe_bitmanip

`default_nettype wire

// ==== src/exe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_ctrl (
   input  logic              clk,
   input  logic              arst_n_i,
   input  logic              in_valid_i,
   output logic              in_ready_o,
   output logic              out_valid_o,
   input  logic              out_ready_i,
   input  exe_pkg::exe_op_e  op_i,
   input  logic              branch_req_i,
   input  logic              jump_req_i,
   input  exe_pkg::xlen_t    alu_result_i,
   input  exe_pkg::xlen_t    bmu_result_i,
   input  exe_pkg::xlen_t    mul_result_i,
   input  logic              branch_taken_i,
   output exe_pkg::xlen_t    result_o,
   output logic              new_pc_req_o,
   output exe_pkg::xlen_t    pc_new_o
);
   import exe_pkg::*;

   exe_unit_e unit;
   xlen_t     result_sel;
   logic      accept;

   // Decode the op range into a result source
   always_comb begin
      if (op_i >= OP_MUL) begin
         unit = UNIT_MUL;
      end else if (op_i >= OP_SH1ADD) begin
         unit = UNIT_BMU;
      end else begin
         unit = UNIT_ALU;
      end
   end

   always_comb begin
      case (unit)
         UNIT_BMU: result_sel = bmu_result_i;
         UNIT_MUL: result_sel = mul_result_i;
         default:  result_sel = alu_result_i;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Handshake and output register
   ////////////////////////////////////////////////////////////////////////////

   // Ready when empty or being drained this cycle
   assign in_ready_o = ~out_valid_o | out_ready_i;
   assign accept     = in_valid_i & in_ready_o;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         out_valid_o  <= 1'b0;
         new_pc_req_o <= 1'b0;
      end else if (in_ready_o) begin
         out_valid_o  <= in_valid_i;
         new_pc_req_o <= in_valid_i & (jump_req_i | (branch_req_i & branch_taken_i));
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         result_o <= result_sel;
         pc_new_o <= {alu_result_i[XLEN-1:2], 2'b00};
      end
   end

endmodule : exe_ctrl

`default_nettype wire

// ==== src/exe_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_mul (
   exe_opr_if.user           opr,
   input  exe_pkg::exe_op_e  op_i,
   output exe_pkg::xlen_t    mul_result_o
);
   import exe_pkg::*;

   logic                     opr1_signed;
   logic                     opr2_signed;
   logic signed [XLEN:0]     mul_opr1;
   logic signed [XLEN:0]     mul_opr2;
   logic signed [2*XLEN+1:0] mul_prod;

   // rs1 is signed for mulh and mulhsu, rs2 only for mulh
   assign opr1_signed = (op_i == OP_MULH) || (op_i == OP_MULHSU);
   assign opr2_signed = (op_i == OP_MULH);

   // One extra sign bit covers all three signedness cases
   assign mul_opr1 = $signed({opr1_signed & opr.opr1[XLEN-1], opr.opr1});
   assign mul_opr2 = $signed({opr2_signed & opr.opr2[XLEN-1], opr.opr2});
   assign mul_prod = (2*XLEN+2)'(mul_opr1) * (2*XLEN+2)'(mul_opr2);

   assign mul_result_o = (op_i == OP_MUL) ? mul_prod[XLEN-1:0] : mul_prod[2*XLEN-1:XLEN];

endmodule : exe_mul

`default_nettype wire

// ==== src/exe_operand_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_operand_sel (
   input  exe_pkg::xlen_t     pc_i,
   input  exe_pkg::xlen_t     imm_i,
   input  exe_pkg::xlen_t     rs1_data_i,
   input  exe_pkg::xlen_t     rs2_data_i,
   input  exe_pkg::xlen_t     lsu_fb_data_i,
   input  exe_pkg::xlen_t     wrb_fb_data_i,
   input  logic               fwd_lsu_rs1_i,
   input  logic               fwd_wrb_rs1_i,
   input  logic               fwd_lsu_rs2_i,
   input  logic               fwd_wrb_rs2_i,
   input  exe_pkg::opr1_sel_e opr1_sel_i,
   input  exe_pkg::opr2_sel_e opr2_sel_i,
   input  exe_pkg::opr2_sel_e cmp_opr2_sel_i,
   exe_opr_if.src             opr
);
   import exe_pkg::*;

   xlen_t rs1_fwd;
   xlen_t rs2_fwd;

   // LSU feedback is the youngest value, so it wins over writeback
   assign rs1_fwd = fwd_lsu_rs1_i ? lsu_fb_data_i :
                    fwd_wrb_rs1_i ? wrb_fb_data_i : rs1_data_i;
   assign rs2_fwd = fwd_lsu_rs2_i ? lsu_fb_data_i :
                    fwd_wrb_rs2_i ? wrb_fb_data_i : rs2_data_i;

   // Datapath operands
   assign opr.opr1 = (opr1_sel_i == OPR1_PC)  ? pc_i  : rs1_fwd;
   assign opr.opr2 = (opr2_sel_i == OPR2_IMM) ? imm_i : rs2_fwd;

   // Comparison operands, rs1 is always the register
   assign opr.cmp_opr1 = rs1_fwd;
   assign opr.cmp_opr2 = (cmp_opr2_sel_i == OPR2_IMM) ? imm_i : rs2_fwd;

endmodule : exe_operand_sel

`default_nettype wire

// ==== src/exe_opr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface exe_opr_if;
   import exe_pkg::*;

   xlen_t opr1;
   xlen_t opr2;
   xlen_t cmp_opr1;
   xlen_t cmp_opr2;
   logic  cmp_lt;
   logic  cmp_ltu;
   logic  cmp_eq;

   modport src  (output opr1, opr2, cmp_opr1, cmp_opr2);
   modport cmp  (input opr1, opr2, cmp_opr1, cmp_opr2, output cmp_lt, cmp_ltu, cmp_eq);
   // Read-only view for bitmanip and multiply
   modport user (input opr1, opr2, cmp_lt, cmp_ltu);

endinterface : exe_opr_if

`default_nettype wire

// ==== src/exe_pkg.sv ====
`default_nettype none

package exe_pkg;

   // Datapath widths
   localparam int XLEN    = 32;
   localparam int CNT_W   = 6;
   localparam int SHAMT_W = 5;

   typedef logic [XLEN-1:0] xlen_t;

   ////////////////////////////////////////////////////////////////////////////
   // Unified opcode, grouped as ALU, bitmanip and multiply ranges
   ////////////////////////////////////////////////////////////////////////////
   typedef enum logic [5:0] {
      // Base integer ALU
      OP_ADD    = 6'd0,
      OP_SUB    = 6'd1,
      OP_AND    = 6'd2,
      OP_OR     = 6'd3,
      OP_XOR    = 6'd4,
      OP_SLL    = 6'd5,
      OP_SRL    = 6'd6,
      OP_SRA    = 6'd7,
      OP_SLT    = 6'd8,
      OP_SLTU   = 6'd9,
      OP_COPY1  = 6'd10,
      OP_COPY2  = 6'd11,
      // Zba/Zbb subset
      OP_SH1ADD = 6'd16,
      OP_SH2ADD = 6'd17,
      OP_SH3ADD = 6'd18,
      OP_ANDN   = 6'd19,
      OP_ORN    = 6'd20,
      OP_XNOR   = 6'd21,
      OP_CLZ    = 6'd22,
      OP_CTZ    = 6'd23,
      OP_CPOP   = 6'd24,
      OP_MIN    = 6'd25,
      OP_MAX    = 6'd26,
      OP_MINU   = 6'd27,
      OP_MAXU   = 6'd28,
      OP_SEXTB  = 6'd29,
      OP_SEXTH  = 6'd30,
      OP_ZEXTH  = 6'd31,
      OP_ROL    = 6'd32,
      OP_ROR    = 6'd33,
      OP_ORCB   = 6'd34,
      OP_REV8   = 6'd35,
      // Multiplier
      OP_MUL    = 6'd48,
      OP_MULH   = 6'd49,
      OP_MULHSU = 6'd50,
      OP_MULHU  = 6'd51
   } exe_op_e;

   typedef enum logic [2:0] {
      BR_NONE,
      BR_EQ,
      BR_NE,
      BR_LT,
      BR_GE,
      BR_LTU,
      BR_GEU
   } br_op_e;

   typedef enum logic {OPR1_REG, OPR1_PC} opr1_sel_e;
   typedef enum logic {OPR2_REG, OPR2_IMM} opr2_sel_e;

   // Result source of the stage
   typedef enum logic [1:0] {UNIT_ALU, UNIT_BMU, UNIT_MUL} exe_unit_e;

endpackage : exe_pkg

`default_nettype wire

// ==== src/exe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_top (
   input  logic               clk,
   input  logic               arst_n_i,
   // Input handshake and operation
   input  logic               in_valid_i,
   output logic               in_ready_o,
   input  exe_pkg::exe_op_e   op_i,
   input  exe_pkg::br_op_e    br_op_i,
   input  exe_pkg::opr1_sel_e opr1_sel_i,
   input  exe_pkg::opr2_sel_e opr2_sel_i,
   input  exe_pkg::opr2_sel_e cmp_opr2_sel_i,
   input  logic               branch_req_i,
   input  logic               jump_req_i,
   // Operand data
   input  exe_pkg::xlen_t     pc_i,
   input  exe_pkg::xlen_t     imm_i,
   input  exe_pkg::xlen_t     rs1_data_i,
   input  exe_pkg::xlen_t     rs2_data_i,
   // Forwarding from LSU and writeback
   input  exe_pkg::xlen_t     lsu_fb_data_i,
   input  exe_pkg::xlen_t     wrb_fb_data_i,
   input  logic               fwd_lsu_rs1_i,
   input  logic               fwd_wrb_rs1_i,
   input  logic               fwd_lsu_rs2_i,
   input  logic               fwd_wrb_rs2_i,
   // Output handshake and results
   output logic               out_valid_o,
   input  logic               out_ready_i,
   output exe_pkg::xlen_t     result_o,
   output logic               new_pc_req_o,
   output exe_pkg::xlen_t     pc_new_o
);
   import exe_pkg::*;

   xlen_t alu_result;
   xlen_t bmu_result;
   xlen_t mul_result;
   logic  branch_taken;

   exe_opr_if opr_bus ();

   exe_operand_sel u_operand_sel (
      .pc_i           (pc_i),
      .imm_i          (imm_i),
      .rs1_data_i     (rs1_data_i),
      .rs2_data_i     (rs2_data_i),
      .lsu_fb_data_i  (lsu_fb_data_i),
      .wrb_fb_data_i  (wrb_fb_data_i),
      .fwd_lsu_rs1_i  (fwd_lsu_rs1_i),
      .fwd_wrb_rs1_i  (fwd_wrb_rs1_i),
      .fwd_lsu_rs2_i  (fwd_lsu_rs2_i),
      .fwd_wrb_rs2_i  (fwd_wrb_rs2_i),
      .opr1_sel_i     (opr1_sel_i),
      .opr2_sel_i     (opr2_sel_i),
      .cmp_opr2_sel_i (cmp_opr2_sel_i),
      .opr            (opr_bus.src)
   );

   exe_alu u_alu (
      .opr            (opr_bus.cmp),
      .op_i           (op_i),
      .br_op_i        (br_op_i),
      .alu_result_o   (alu_result),
      .branch_taken_o (branch_taken)
   );

   exe_bitmanip u_bitmanip (
      .opr          (opr_bus.user),
      .op_i         (op_i),
      .bmu_result_o (bmu_result)
   );

   exe_mul u_mul (
      .opr          (opr_bus.user),
      .op_i         (op_i),
      .mul_result_o (mul_result)
   );

   exe_ctrl u_ctrl (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .in_valid_i     (in_valid_i),
      .in_ready_o     (in_ready_o),
      .out_valid_o    (out_valid_o),
      .out_ready_i    (out_ready_i),
      .op_i           (op_i),
      .branch_req_i   (branch_req_i),
      .jump_req_i     (jump_req_i),
      .alu_result_i   (alu_result),
      .bmu_result_i   (bmu_result),
      .mul_result_i   (mul_result),
      .branch_taken_i (branch_taken),
      .result_o       (result_o),
      .new_pc_req_o   (new_pc_req_o),
      .pc_new_o       (pc_new_o)
   );

endmodule : exe_top

`default_nettype wire

// ==== tb/tb_exe_tasks.svh ====
`ifndef TB_EXE_TASKS_SVH
`define TB_EXE_TASKS_SVH

// One operation with all of its operand and control inputs
typedef struct {
   exe_op_e    op;
   br_op_e     br_op;
   opr1_sel_e  s1;
   opr2_sel_e  s2;
   opr2_sel_e  cs2;
   logic       br;
   logic       jmp;
   xlen_t      pc;
   xlen_t      imm;
   xlen_t      rs1;
   xlen_t      rs2;
   xlen_t      lsu;
   xlen_t      wrb;
   // lsu_rs1, wrb_rs1, lsu_rs2, wrb_rs2
   logic [3:0] fwd;
} op_t;

////////////////////////////////////////////////////////////////////////////
// Random numbers
////////////////////////////////////////////////////////////////////////////

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic next_lfsr_bit();
   logic out;
   out        = lfsr_state[0];
   lfsr_state = lfsr_state >> 1;
   if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
   end
   return out;
endfunction

function automatic xlen_t rand_word();
   xlen_t w;
   for (int i = 0; i < XLEN; i++) begin
      w[i] = next_lfsr_bit();
   end
   return w;
endfunction

////////////////////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////////////////////

function automatic op_t reg_op(exe_op_e op, xlen_t a, xlen_t b);
   op_t t;
   t.op    = op;
   t.br_op = BR_NONE;
   t.s1    = OPR1_REG;
   t.s2    = OPR2_REG;
   t.cs2   = OPR2_REG;
   t.br    = 1'b0;
   t.jmp   = 1'b0;
   t.pc    = '0;
   t.imm   = '0;
   t.rs1   = a;
   t.rs2   = b;
   t.lsu   = '0;
   t.wrb   = '0;
   t.fwd   = 4'b0000;
   return t;
endfunction

function automatic xlen_t fwd_value(logic use_lsu, logic use_wrb, xlen_t lsu, xlen_t wrb,
                                    xlen_t regv);
   if (use_lsu) begin
      return lsu;
   end
   if (use_wrb) begin
      return wrb;
   end
   return regv;
endfunction

function automatic xlen_t count_bits(xlen_t a, int mode);
   int   n;
   logic stop;
   n    = 0;
   stop = 1'b0;
   for (int i = 0; i < XLEN; i++) begin
      case (mode)
         // Leading zeros, scanned from the MSB
         0: begin
            if (a[XLEN-1-i]) stop = 1'b1;
            else if (!stop) n++;
         end
         1: begin
            if (a[i]) stop = 1'b1;
            else if (!stop) n++;
         end
         default: if (a[i]) n++;
      endcase
   end
   return xlen_t'(n);
endfunction

function automatic xlen_t model_result(op_t t);
   xlen_t        r1;
   xlen_t        r2;
   xlen_t        a;
   xlen_t        b;
   xlen_t        cb;
   logic         lt;
   logic         ltu;
   int           s;
   xlen_t        r;
   logic [63:0]  p;
   r1  = fwd_value(t.fwd[3], t.fwd[2], t.lsu, t.wrb, t.rs1);
   r2  = fwd_value(t.fwd[1], t.fwd[0], t.lsu, t.wrb, t.rs2);
   a   = (t.s1 == OPR1_PC) ? t.pc : r1;
   b   = (t.s2 == OPR2_IMM) ? t.imm : r2;
   cb  = (t.cs2 == OPR2_IMM) ? t.imm : r2;
   lt  = $signed(r1) < $signed(cb);
   ltu = r1 < cb;
   s   = int'(b[4:0]);
   r   = '0;
   case (t.op)
      OP_ADD:    r = a + b;
      OP_SUB:    r = a - b;
      OP_AND:    r = a & b;
      OP_OR:     r = a | b;
      OP_XOR:    r = a ^ b;
      OP_SLL:    r = a << s;
      OP_SRL:    r = a >> s;
      OP_SRA:    r = xlen_t'($signed(a) >>> s);
      OP_SLT:    r = lt ? 32'd1 : 32'd0;
      OP_SLTU:   r = ltu ? 32'd1 : 32'd0;
      OP_COPY1:  r = a;
      OP_COPY2:  r = b;
      OP_SH1ADD: r = a * 2 + b;
      OP_SH2ADD: r = a * 4 + b;
      OP_SH3ADD: r = a * 8 + b;
      OP_ANDN:   r = a & ~b;
      OP_ORN:    r = a | ~b;
      OP_XNOR:   r = ~(a ^ b);
      OP_CLZ:    r = count_bits(a, 0);
      OP_CTZ:    r = count_bits(a, 1);
      OP_CPOP:   r = count_bits(a, 2);
      OP_MIN:    r = lt ? a : b;
      OP_MAX:    r = lt ? b : a;
      OP_MINU:   r = ltu ? a : b;
      OP_MAXU:   r = ltu ? b : a;
      OP_SEXTB:  r = xlen_t'(longint'($signed(a[7:0])));
      OP_SEXTH:  r = xlen_t'(longint'($signed(a[15:0])));
      OP_ZEXTH:  r = a & 32'h0000_ffff;
      OP_ROL:    r = (a << s) | (a >> (XLEN - s));
      OP_ROR:    r = (a >> s) | (a << (XLEN - s));
      OP_ORCB: begin
         for (int k = 0; k < 4; k++) begin
            r[8*k +: 8] = (a[8*k +: 8] != 8'h00) ? 8'hff : 8'h00;
         end
      end
      OP_REV8: begin
         for (int k = 0; k < 4; k++) begin
            r[8*k +: 8] = a[8*(3-k) +: 8];
         end
      end
      OP_MUL: begin
         p = {32'b0, a} * {32'b0, b};
         r = p[31:0];
      end
      OP_MULH: begin
         p = 64'(longint'($signed(a)) * longint'($signed(b)));
         r = p[63:32];
      end
      OP_MULHSU: begin
         p = 64'(longint'($signed(a)) * longint'({32'b0, b}));
         r = p[63:32];
      end
      OP_MULHU: begin
         p = {32'b0, a} * {32'b0, b};
         r = p[63:32];
      end
      default:   r = '0;
   endcase
   return r;
endfunction

function automatic logic model_pc_req(op_t t);
   xlen_t a;
   xlen_t b;
   logic  taken;
   a = fwd_value(t.fwd[3], t.fwd[2], t.lsu, t.wrb, t.rs1);
   b = (t.cs2 == OPR2_IMM) ? t.imm : fwd_value(t.fwd[1], t.fwd[0], t.lsu, t.wrb, t.rs2);
   case (t.br_op)
      BR_EQ:   taken = (a == b);
      BR_NE:   taken = (a != b);
      BR_LT:   taken = $signed(a) < $signed(b);
      BR_GE:   taken = $signed(a) >= $signed(b);
      BR_LTU:  taken = a < b;
      BR_GEU:  taken = a >= b;
      default: taken = 1'b0;
   endcase
   return t.jmp | (t.br & taken);
endfunction

////////////////////////////////////////////////////////////////////////////
// Checks and drivers
////////////////////////////////////////////////////////////////////////////

task automatic check_word(string name, xlen_t exp, xlen_t act);
   check_cnt++;
   if (exp !== act) begin
      error_cnt++;
      test_errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
   end
endtask

task automatic check_bit(string name, logic exp, logic act);
   check_cnt++;
   if (exp !== act) begin
      error_cnt++;
      test_errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
   end
endtask

task automatic end_test(string name);
   if (test_errors == 0) begin
      tests_passed++;
      $display("Test %s: passed", name);
   end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, test_errors);
   end
   test_errors = 0;
endtask

// Called right after a rising edge
task automatic apply_op(op_t t);
   in_valid_i     <= 1'b1;
   op_i           <= t.op;
   br_op_i        <= t.br_op;
   opr1_sel_i     <= t.s1;
   opr2_sel_i     <= t.s2;
   cmp_opr2_sel_i <= t.cs2;
   branch_req_i   <= t.br;
   jump_req_i     <= t.jmp;
   pc_i           <= t.pc;
   imm_i          <= t.imm;
   rs1_data_i     <= t.rs1;
   rs2_data_i     <= t.rs2;
   lsu_fb_data_i  <= t.lsu;
   wrb_fb_data_i  <= t.wrb;
   fwd_lsu_rs1_i  <= t.fwd[3];
   fwd_wrb_rs1_i  <= t.fwd[2];
   fwd_lsu_rs2_i  <= t.fwd[1];
   fwd_wrb_rs2_i  <= t.fwd[0];
endtask

// Returns on the rising edge that transfers the operation
task automatic wait_transfer();
   @(negedge clk);
   while (!in_ready_o) @(negedge clk);
   @(posedge clk);
endtask

task automatic wait_output();
   @(negedge clk);
   while (!out_valid_o) @(negedge clk);
endtask

task automatic exec_op(op_t t, string name);
   @(posedge clk);
   apply_op(t);
   wait_transfer();
   in_valid_i <= 1'b0;
   wait_output();
   check_word(name, model_result(t), result_o);
   check_bit({name, " pc_req"}, model_pc_req(t), new_pc_req_o);
   if (t.br || t.jmp) begin
      check_word({name, " pc_new"}, model_result(t) & 32'hffff_fffc, pc_new_o);
   end
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic test_reset();
   @(negedge clk);
   check_bit("reset out_valid", 1'b0, out_valid_o);
   check_bit("reset pc_req", 1'b0, new_pc_req_o);
   check_bit("reset in_ready", 1'b1, in_ready_o);
   end_test("reset");
endtask

task automatic test_alu();
   op_t t;
   for (int round = 0; round < 4; round++) begin
      for (int k = 0; k <= 11; k++) begin
         t     = reg_op(exe_op_e'(k), rand_word(), rand_word());
         t.pc  = rand_word();
         t.imm = rand_word();
         if (round == 1 || round == 3) t.s1 = OPR1_PC;
         if (round >= 2) begin
            t.s2  = OPR2_IMM;
            t.cs2 = OPR2_IMM;
         end
         exec_op(t, $sformatf("alu %s r%0d", t.op.name(), round));
      end
   end
   end_test("alu");
endtask

// Sign boundary, equal and unsigned extreme operand pairs
function automatic logic [63:0] edge_pair(int i);
   case (i)
      0:       return {32'h7fff_ffff, 32'h8000_0000};
      1:       return {32'h8000_0000, 32'h7fff_ffff};
      2:       return {32'h0000_0005, 32'h0000_0005};
      3:       return {32'hffff_ffff, 32'h0000_0000};
      4:       return {32'h0000_0000, 32'hffff_ffff};
      default: return {32'h8000_0000, 32'h8000_0000};
   endcase
endfunction

task automatic test_branch();
   op_t         t;
   logic [63:0] pr;
   for (int i = 0; i < 6; i++) begin
      pr = edge_pair(i);
      exec_op(reg_op(OP_SLT, pr[63:32], pr[31:0]), $sformatf("slt pair %0d", i));
      exec_op(reg_op(OP_SLTU, pr[63:32], pr[31:0]), $sformatf("sltu pair %0d", i));
   end
   for (int c = 0; c <= 6; c++) begin
      for (int i = 2; i < 5; i++) begin
         pr      = edge_pair(i);
         t       = reg_op(OP_ADD, pr[63:32], pr[31:0]);
         t.br_op = br_op_e'(c);
         t.br    = 1'b1;
         t.s1    = OPR1_PC;
         t.s2    = OPR2_IMM;
         t.pc    = rand_word();
         t.imm   = rand_word();
         exec_op(t, $sformatf("branch %s pair %0d", t.br_op.name(), i));
      end
   end
   t     = reg_op(OP_ADD, rand_word(), rand_word());
   t.jmp = 1'b1;
   exec_op(t, "jump");
   end_test("branch");
endtask

task automatic test_forward();
   op_t t;
   for (int f = 0; f < 16; f++) begin
      t     = reg_op(OP_SUB, rand_word(), rand_word());
      t.lsu = rand_word();
      t.wrb = rand_word();
      t.fwd = 4'(f);
      exec_op(t, $sformatf("forward %b", t.fwd));
   end
   end_test("forward");
endtask

function automatic xlen_t mul_extreme(int i);
   case (i)
      0:       return 32'h8000_0000;
      1:       return 32'h7fff_ffff;
      2:       return 32'hffff_ffff;
      default: return 32'h0000_0001;
   endcase
endfunction

task automatic test_mul();
   exe_op_e op;
   for (int k = 48; k <= 51; k++) begin
      op = exe_op_e'(k);
      for (int i = 0; i < 4; i++) begin
         for (int j = 0; j < 4; j++) begin
            exec_op(reg_op(op, mul_extreme(i), mul_extreme(j)),
                    $sformatf("%s extreme %0d %0d", op.name(), i, j));
         end
      end
      for (int i = 0; i < 4; i++) begin
         exec_op(reg_op(op, rand_word(), rand_word()), $sformatf("%s rand %0d", op.name(), i));
      end
   end
   end_test("mul");
endtask

task automatic test_bitmanip();
   xlen_t   v;
   exe_op_e op;
   for (int k = 22; k <= 24; k++) begin
      op = exe_op_e'(k);
      for (int i = 0; i < 6; i++) begin
         case (i)
            0:       v = 32'h0000_0000;
            1:       v = 32'hffff_ffff;
            2:       v = 32'h0000_0001;
            3:       v = 32'h8000_0000;
            default: v = rand_word();
         endcase
         exec_op(reg_op(op, v, '0), $sformatf("%s value %h", op.name(), v));
      end
   end
   for (int round = 0; round < 3; round++) begin
      for (int k = 16; k <= 35; k++) begin
         if (k < 22 || k > 24) begin
            op = exe_op_e'(k);
            if (round == 2) begin
               exec_op(reg_op(op, 32'h8000_0000, 32'h0000_0001),
                       $sformatf("%s edge", op.name()));
            end else begin
               exec_op(reg_op(op, rand_word(), rand_word()),
                       $sformatf("%s r%0d", op.name(), round));
            end
         end
      end
   end
   end_test("bitmanip");
endtask

task automatic test_backpressure();
   op_t first;
   op_t second;
   first  = reg_op(OP_ADD, rand_word(), rand_word());
   second = reg_op(OP_XOR, rand_word(), rand_word());
   @(posedge clk);
   out_ready_i <= 1'b0;
   apply_op(first);
   wait_transfer();
   apply_op(second);
   repeat (3) begin
      @(negedge clk);
      check_bit("stall out_valid", 1'b1, out_valid_o);
      check_bit("stall in_ready", 1'b0, in_ready_o);
      check_word("stall hold", model_result(first), result_o);
   end
   @(posedge clk);
   out_ready_i <= 1'b1;
   @(negedge clk);
   check_bit("release in_ready", 1'b1, in_ready_o);
   check_word("release first", model_result(first), result_o);
   @(posedge clk);
   in_valid_i <= 1'b0;
   @(negedge clk);
   check_bit("release second valid", 1'b1, out_valid_o);
   check_word("release second", model_result(second), result_o);
   @(posedge clk);
   @(negedge clk);
   // Nothing more may come out after the two results
   if (out_valid_o) begin
      error_cnt++;
      test_errors++;
      $display("Back-pressure: an extra result appeared after the queue drained");
   end
   end_test("backpressure");
endtask

`endif

// ==== tb/tb_exe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exe_top;
   import exe_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int LFSR_SEED  = 47;
   // Number of operations in all tests, rounded up
   localparam int NUM_OPS    = 260;
   localparam int TIMEOUT    = NUM_OPS * 4 + 100;

   logic       clk;
   logic       arst_n_i;
   logic       in_valid_i;
   logic       in_ready_o;
   exe_op_e    op_i;
   br_op_e     br_op_i;
   opr1_sel_e  opr1_sel_i;
   opr2_sel_e  opr2_sel_i;
   opr2_sel_e  cmp_opr2_sel_i;
   logic       branch_req_i;
   logic       jump_req_i;
   xlen_t      pc_i;
   xlen_t      imm_i;
   xlen_t      rs1_data_i;
   xlen_t      rs2_data_i;
   xlen_t      lsu_fb_data_i;
   xlen_t      wrb_fb_data_i;
   logic       fwd_lsu_rs1_i;
   logic       fwd_wrb_rs1_i;
   logic       fwd_lsu_rs2_i;
   logic       fwd_wrb_rs2_i;
   logic       out_valid_o;
   logic       out_ready_i;
   xlen_t      result_o;
   logic       new_pc_req_o;
   xlen_t      pc_new_o;

   logic [31:0] lfsr_state;
   int          cycle_cnt;
   int          check_cnt;
   int          error_cnt;
   int          test_errors;
   int          tests_passed;
   int          tests_failed;

   exe_top UUT (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .in_valid_i     (in_valid_i),
      .in_ready_o     (in_ready_o),
      .op_i           (op_i),
      .br_op_i        (br_op_i),
      .opr1_sel_i     (opr1_sel_i),
      .opr2_sel_i     (opr2_sel_i),
      .cmp_opr2_sel_i (cmp_opr2_sel_i),
      .branch_req_i   (branch_req_i),
      .jump_req_i     (jump_req_i),
      .pc_i           (pc_i),
      .imm_i          (imm_i),
      .rs1_data_i     (rs1_data_i),
      .rs2_data_i     (rs2_data_i),
      .lsu_fb_data_i  (lsu_fb_data_i),
      .wrb_fb_data_i  (wrb_fb_data_i),
      .fwd_lsu_rs1_i  (fwd_lsu_rs1_i),
      .fwd_wrb_rs1_i  (fwd_wrb_rs1_i),
      .fwd_lsu_rs2_i  (fwd_lsu_rs2_i),
      .fwd_wrb_rs2_i  (fwd_wrb_rs2_i),
      .out_valid_o    (out_valid_o),
      .out_ready_i    (out_ready_i),
      .result_o       (result_o),
      .new_pc_req_o   (new_pc_req_o),
      .pc_new_o       (pc_new_o)
   );

`include "tb_exe_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Watchdog
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT) begin
         $display("Timeout: no result after %0d cycles", cycle_cnt);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   initial begin
      lfsr_state     = 32'(LFSR_SEED);
      cycle_cnt      = 0;
      check_cnt      = 0;
      error_cnt      = 0;
      test_errors    = 0;
      tests_passed   = 0;
      tests_failed   = 0;
      arst_n_i       = 1'b0;
      in_valid_i     = 1'b0;
      out_ready_i    = 1'b1;
      op_i           = OP_ADD;
      br_op_i        = BR_NONE;
      opr1_sel_i     = OPR1_REG;
      opr2_sel_i     = OPR2_REG;
      cmp_opr2_sel_i = OPR2_REG;
      branch_req_i   = 1'b0;
      jump_req_i     = 1'b0;
      pc_i           = '0;
      imm_i          = '0;
      rs1_data_i     = '0;
      rs2_data_i     = '0;
      lsu_fb_data_i  = '0;
      wrb_fb_data_i  = '0;
      fwd_lsu_rs1_i  = 1'b0;
      fwd_wrb_rs1_i  = 1'b0;
      fwd_lsu_rs2_i  = 1'b0;
      fwd_wrb_rs2_i  = 1'b0;

      // Reset held for two cycles
      repeat (2) @(posedge clk);
      arst_n_i <= 1'b1;

      test_reset();
      test_alu();
      test_branch();
      test_forward();
      test_mul();
      test_bitmanip();
      test_backpressure();

      $display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
               tests_passed, tests_failed, check_cnt, error_cnt);
      if (error_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule : tb_exe_top

`default_nettype wire
